// ==== include/xbuf_cfg.svh ====
// ----------------------------------------
// X stream configuration
// Element width, tile geometry and slots
// ----------------------------------------

`ifndef XBUF_CFG_SVH
`define XBUF_CFG_SVH

// Element and weight width in bits
`define XB_ELEM_W 8

// Elements carried by one input beat
`define XB_H 4

// Rows per tile, also the number of result sums
`define XB_W 4

// Longest supported row, K is 4 or 8
`define XB_KMAX 8

// Tile slots in the buffer, equal to the initial credit count
`define XB_SLOTS 2

// Accumulator width, holds KMAX products of two elements
`define XB_ACC_W 20

`endif

// ==== logic/xbuf_pkg.sv ====
// ----------------------------------------
// X stream types
// Beats, columns, configuration, results
// ----------------------------------------

`include "xbuf_cfg.svh"

package xbuf_pkg;

  // One unsigned element
  typedef logic [`XB_ELEM_W-1:0] elem_t;

  // One input beat, H elements of a tile row
  typedef struct packed {
    elem_t [`XB_H-1:0] data;
  } x_beat_t;

  // Run configuration, stable for a whole test
  typedef struct packed {
    logic [$clog2(`XB_KMAX):0] k_len;
    elem_t [`XB_KMAX-1:0]      weights;
  } xb_cfg_t;

  // One tile column, element w comes from row w
  typedef struct packed {
    elem_t [`XB_W-1:0] data;
  } x_col_t;

  // Result vector of one tile, y = X * w
  typedef struct packed {
    logic [`XB_W-1:0][`XB_ACC_W-1:0] y;
  } dot_res_t;

  // Read side of the tile buffer
  typedef enum logic {
    RD_IDLE,
    RD_STREAM
  } buf_rd_state_e;

endpackage : xbuf_pkg

// ==== logic/x_row_loader.sv ====
// ----------------------------------------
// X row loader
// Forwards input beats while credits last
// ----------------------------------------

`timescale 1ns/1ps
`include "xbuf_cfg.svh"

module x_row_loader (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  xbuf_pkg::xb_cfg_t cfg_i,
  input  logic              row_valid_i,
  input  xbuf_pkg::x_beat_t row_i,
  output logic              row_ready_o,
  output logic              beat_valid_o,
  output xbuf_pkg::x_beat_t beat_o,
  input  logic              credit_i
);

  localparam int unsigned MAX_BEATS = `XB_W * `XB_KMAX / `XB_H;
  localparam int unsigned BEAT_W    = $clog2(MAX_BEATS + 1);
  localparam int unsigned CREDIT_W  = $clog2(`XB_SLOTS + 1);

  logic [CREDIT_W-1:0] credit_q;
  logic [BEAT_W-1:0]   beat_cnt_q;
  logic [BEAT_W-1:0]   tile_beats;
  logic                init_q;
  logic                has_credit;
  logic                last_beat;

  // Handshake passes straight through, gated by the credit count
  assign has_credit   = (credit_q != '0);
  assign row_ready_o  = has_credit;
  assign beat_valid_o = row_valid_i & has_credit;
  assign beat_o       = row_i;

  // Beats per tile is W*K/H
  assign tile_beats = BEAT_W'(int'(cfg_i.k_len) * `XB_W / `XB_H);
  assign last_beat  = beat_valid_o && (beat_cnt_q == tile_beats - 1'b1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_cnt_q <= '0;
    end else if (beat_valid_o) begin
      beat_cnt_q <= last_beat ? '0 : beat_cnt_q + 1'b1;
    end
  end

  // Counter loads the slot count one cycle after reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      init_q   <= 1'b0;
      credit_q <= '0;
    end else if (!init_q) begin
      init_q   <= 1'b1;
      credit_q <= CREDIT_W'(`XB_SLOTS);
    end else begin
      // A returned credit and a spent one may cancel out
      case ({credit_i, last_beat})
        2'b10: begin
          credit_q <= credit_q + 1'b1;
        end
        2'b01: begin
          credit_q <= credit_q - 1'b1;
        end
        default: begin
          credit_q <= credit_q;
        end
      endcase
    end
  end

endmodule : x_row_loader

// ==== logic/x_tile_buffer.sv ====
// ----------------------------------------
// X tile buffer
// Two-slot tile store with column reads
// ----------------------------------------

`timescale 1ns/1ps
`include "xbuf_cfg.svh"

module x_tile_buffer (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  xbuf_pkg::xb_cfg_t cfg_i,
  input  logic              beat_valid_i,
  input  xbuf_pkg::x_beat_t beat_i,
  output logic              credit_o,
  output logic              col_valid_o,
  output xbuf_pkg::x_col_t  col_o,
  input  logic              shift_i
);

  localparam int unsigned CHUNKS  = `XB_KMAX / `XB_H;
  localparam int unsigned CHUNK_W = (CHUNKS > 1) ? $clog2(CHUNKS) : 1;
  localparam int unsigned ROW_W   = (`XB_W > 1) ? $clog2(`XB_W) : 1;
  localparam int unsigned COL_W   = $clog2(`XB_KMAX);
  localparam int unsigned SLOT_W  = (`XB_SLOTS > 1) ? $clog2(`XB_SLOTS) : 1;

  // Tile storage, slot by row by element
  xbuf_pkg::elem_t mem_q [`XB_SLOTS][`XB_W][`XB_KMAX];

  logic [SLOT_W-1:0]    wr_slot_q;
  logic [SLOT_W-1:0]    rd_slot_q;
  logic [ROW_W-1:0]     row_q;
  logic [CHUNK_W-1:0]   chunk_q;
  logic [COL_W-1:0]     col_q;
  logic [`XB_SLOTS-1:0] full_q;
  logic                 credit_q;
  logic                 chunk_last;
  logic                 row_last;
  logic                 tile_done;
  logic                 col_last;
  logic                 rd_done;

  xbuf_pkg::buf_rd_state_e state_q;

  // Write side

  // K/H chunks make up one row
  assign chunk_last = (chunk_q == CHUNK_W'(cfg_i.k_len / `XB_H - 1));
  assign row_last   = (row_q == ROW_W'(`XB_W - 1));
  assign tile_done  = beat_valid_i && chunk_last && row_last;

  always_ff @(posedge clk_i) begin
    if (beat_valid_i) begin
      for (int h = 0; h < `XB_H; h++) begin
        mem_q[wr_slot_q][row_q][int'(chunk_q) * `XB_H + h] <= beat_i.data[h];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_slot_q <= '0;
      row_q     <= '0;
      chunk_q   <= '0;
    end else if (beat_valid_i) begin
      if (chunk_last) begin
        chunk_q <= '0;
        row_q   <= row_last ? '0 : row_q + 1'b1;
      end else begin
        chunk_q <= chunk_q + 1'b1;
      end
      if (tile_done) begin
        wr_slot_q <= (wr_slot_q == SLOT_W'(`XB_SLOTS - 1)) ? '0 : wr_slot_q + 1'b1;
      end
    end
  end

  // Read side
  assign col_last = (col_q == COL_W'(cfg_i.k_len - 1));
  assign rd_done  = (state_q == xbuf_pkg::RD_STREAM) && shift_i && col_last;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= xbuf_pkg::RD_IDLE;
      rd_slot_q <= '0;
      col_q     <= '0;
    end else begin
      case (state_q)
        xbuf_pkg::RD_IDLE: begin
          col_q <= '0;
          if (full_q[rd_slot_q]) begin
            state_q <= xbuf_pkg::RD_STREAM;
          end
        end
        xbuf_pkg::RD_STREAM: begin
          if (shift_i) begin
            if (col_last) begin
              col_q     <= '0;
              state_q   <= xbuf_pkg::RD_IDLE;
              rd_slot_q <= (rd_slot_q == SLOT_W'(`XB_SLOTS - 1)) ? '0 : rd_slot_q + 1'b1;
            end else begin
              col_q <= col_q + 1'b1;
            end
          end
        end
        default: begin
          state_q <= xbuf_pkg::RD_IDLE;
        end
      endcase
    end
  end

  // Full flags, set by the writer and cleared by the reader on different slots
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q   <= '0;
      credit_q <= 1'b0;
    end else begin
      for (int s = 0; s < `XB_SLOTS; s++) begin
        if (tile_done && (wr_slot_q == SLOT_W'(s))) begin
          full_q[s] <= 1'b1;
        end else if (rd_done && (rd_slot_q == SLOT_W'(s))) begin
          full_q[s] <= 1'b0;
        end
      end
      credit_q <= rd_done;
    end
  end

  assign credit_o    = credit_q;
  assign col_valid_o = (state_q == xbuf_pkg::RD_STREAM);

  // Column k of the read slot, one element per row
  always_comb begin
    for (int w = 0; w < `XB_W; w++) begin
      col_o.data[w] = mem_q[rd_slot_q][w][col_q];
    end
  end

endmodule : x_tile_buffer

// ==== logic/x_dot_engine.sv ====
// ----------------------------------------
// X dot engine
// Accumulates columns times weights
// ----------------------------------------

`timescale 1ns/1ps
`include "xbuf_cfg.svh"

module x_dot_engine (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  xbuf_pkg::xb_cfg_t  cfg_i,
  input  logic               col_valid_i,
  input  xbuf_pkg::x_col_t   col_i,
  output logic               shift_o,
  output logic               res_valid_o,
  output xbuf_pkg::dot_res_t res_o,
  input  logic               res_ready_i
);

  localparam int unsigned ACC_W = `XB_ACC_W;
  localparam int unsigned COL_W = $clog2(`XB_KMAX);

  logic [ACC_W-1:0]   acc_q  [`XB_W];
  logic [ACC_W-1:0]   sum    [`XB_W];
  logic [COL_W-1:0]   k_q;
  logic               pend_q;
  logic               k_last;
  xbuf_pkg::elem_t    wgt;
  xbuf_pkg::dot_res_t res_q;

  // No shift while a result waits for acceptance
  assign shift_o = col_valid_i & ~pend_q;
  assign k_last  = (k_q == COL_W'(cfg_i.k_len - 1));
  assign wgt     = cfg_i.weights[k_q];

  // Running sums including the current column
  always_comb begin
    for (int w = 0; w < `XB_W; w++) begin
      sum[w] = acc_q[w] + ACC_W'(col_i.data[w]) * ACC_W'(wgt);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      k_q <= '0;
      for (int w = 0; w < `XB_W; w++) begin
        acc_q[w] <= '0;
      end
    end else if (shift_o) begin
      k_q <= k_last ? '0 : k_q + 1'b1;
      for (int w = 0; w < `XB_W; w++) begin
        acc_q[w] <= k_last ? '0 : sum[w];
      end
    end
  end

  // Result register holds the finished vector
  always_ff @(posedge clk_i) begin
    if (shift_o && k_last) begin
      for (int w = 0; w < `XB_W; w++) begin
        res_q.y[w] <= sum[w];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q <= 1'b0;
    end else if (shift_o && k_last) begin
      pend_q <= 1'b1;
    end else if (pend_q && res_ready_i) begin
      pend_q <= 1'b0;
    end
  end

  assign res_valid_o = pend_q;
  assign res_o       = res_q;

endmodule : x_dot_engine

// ==== logic/x_stream_top.sv ====
// ----------------------------------------
// X stream top
// Loader, tile buffer and dot engine
// ----------------------------------------

`timescale 1ns/1ps

module x_stream_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  xbuf_pkg::xb_cfg_t  cfg_i,
  input  logic               row_valid_i,
  input  xbuf_pkg::x_beat_t  row_i,
  output logic               row_ready_o,
  output logic               res_valid_o,
  output xbuf_pkg::dot_res_t res_o,
  input  logic               res_ready_i
);

  logic              beat_valid;
  xbuf_pkg::x_beat_t beat;
  logic              credit;
  logic              col_valid;
  xbuf_pkg::x_col_t  col;
  logic              shift;

  // Credit loop between loader and buffer
  x_row_loader u_loader (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cfg_i        (cfg_i),
    .row_valid_i  (row_valid_i),
    .row_i        (row_i),
    .row_ready_o  (row_ready_o),
    .beat_valid_o (beat_valid),
    .beat_o       (beat),
    .credit_i     (credit)
  );

  x_tile_buffer u_buffer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cfg_i        (cfg_i),
    .beat_valid_i (beat_valid),
    .beat_i       (beat),
    .credit_o     (credit),
    .col_valid_o  (col_valid),
    .col_o        (col),
    .shift_i      (shift)
  );

  // Engine pulls columns in place
  x_dot_engine u_engine (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg_i       (cfg_i),
    .col_valid_i (col_valid),
    .col_i       (col),
    .shift_o     (shift),
    .res_valid_o (res_valid_o),
    .res_o       (res_o),
    .res_ready_i (res_ready_i)
  );

endmodule : x_stream_top

// ==== tests/x_stream_props.sv ====
// ----------------------------------------
// X stream properties
// Credit, result and shift rules
// ----------------------------------------

`timescale 1ns/1ps
`include "xbuf_cfg.svh"

module x_stream_props (
  input logic                        clk_i,
  input logic                        rst_ni,
  input logic [1:0]                  credit,
  input logic                        beat_valid,
  input logic [`XB_SLOTS-1:0]        full,
  input logic                        wr_slot,
  input logic                        rd_slot,
  input logic [$clog2(`XB_KMAX)-1:0] rd_col,
  input logic                        res_valid_o,
  input logic                        res_ready_i,
  input xbuf_pkg::dot_res_t          res_o
);

  a_credit_max: assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit <= `XB_SLOTS) else $error("loader credit above slot count");

  // A beat sent on credit always lands in a free slot
  a_no_overrun: assert property (@(posedge clk_i) disable iff (!rst_ni)
    beat_valid |-> !full[wr_slot]) else $error("beat written into a full slot");

  a_res_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_o))
    else $error("result changed while held");

  // Buffer read position holds while a result waits
  a_no_shift_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_valid_o |=> $stable(rd_col) && $stable(rd_slot))
    else $error("column consumed while result pending");

endmodule : x_stream_props

bind x_stream_top x_stream_props u_props (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .credit      (u_loader.credit_q),
  .beat_valid  (beat_valid),
  .full        (u_buffer.full_q),
  .wr_slot     (u_buffer.wr_slot_q),
  .rd_slot     (u_buffer.rd_slot_q),
  .rd_col      (u_buffer.col_q),
  .res_valid_o (res_valid_o),
  .res_ready_i (res_ready_i),
  .res_o       (res_o)
);

// ==== tests/x_stream_tb.sv ====
// ----------------------------------------
// X stream testbench
// File-driven tiles, checks y = X * w
// ----------------------------------------

`timescale 1ns/1ps
`include "xbuf_cfg.svh"

module x_stream_tb;

  localparam int unsigned MEM_DEPTH = 256;
  localparam int unsigned MAX_TESTS = 16;

  logic               clk_i;
  logic               rst_ni;
  xbuf_pkg::xb_cfg_t  cfg_i;
  logic               row_valid_i;
  xbuf_pkg::x_beat_t  row_i;
  logic               row_ready_o;
  logic               res_valid_o;
  xbuf_pkg::dot_res_t res_o;
  logic               res_ready_i;

  logic [31:0] tmem [MEM_DEPTH];
  int          t_id    [MAX_TESTS];
  int          t_mode  [MAX_TESTS];
  int          t_k     [MAX_TESTS];
  int          t_wbase [MAX_TESTS];
  int          t_tiles [MAX_TESTS];
  int          t_bbase [MAX_TESTS];
  int          t_ebase [MAX_TESTS];
  int          n_tests;
  int          errors;
  int          checks;
  int          limit;
  int          cycles;
  int          beats_sent;
  bit          limit_set;

  x_stream_top u_x_stream_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Run length guard, sized from the test data
  initial begin
    cycles = 0;
    wait (limit_set);
    while (cycles < limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout: results missing");
    $display("TEST FAIL");
    $finish;
  end

  // Input beats that make up one tile of W rows by k elements
  function automatic int beats_per_tile(input int k);
    return `XB_W * k / `XB_H;
  endfunction

  // One input beat, transfer seen when ready is high before the edge
  task automatic send_beat();
    bit done;
    done = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      done = row_ready_o;
      @(posedge clk_i);
      #1;
    end
    beats_sent++;
  endtask

  task automatic drive_tiles(input int idx);
    int n;
    n = t_tiles[idx] * beats_per_tile(t_k[idx]);
    for (int b = 0; b < n; b++) begin
      // Random gaps only in stall mode
      while (t_mode[idx] == 2 && $urandom_range(0, 2) == 0) begin
        row_valid_i = 1'b0;
        @(posedge clk_i);
        #1;
      end
      row_valid_i = 1'b1;
      row_i       = tmem[t_bbase[idx] + b];
      send_beat();
    end
    row_valid_i = 1'b0;
  endtask

  task automatic collect_results(input int idx);
    bit             got;
    bit             stalled;
    int             hold;
    int             stall_beats;
    logic [31:0]    exp;
    stalled = 1'b0;
    hold    = 0;
    if (t_mode[idx] == 1) begin
      // Held result, both slots full, so the input stops after that many tiles
      res_ready_i = 1'b0;
      stall_beats = (`XB_SLOTS + 1) * beats_per_tile(t_k[idx]);
      while (!stalled && hold < limit) begin
        @(negedge clk_i);
        stalled = row_valid_i && !row_ready_o && (beats_sent == stall_beats);
        hold++;
      end
      assert (stalled) else begin
        $display("row_ready_o did not fall after %0d beats while results were held",
                 stall_beats);
        errors++;
      end
      @(posedge clk_i);
      #1;
    end
    res_ready_i = (t_mode[idx] == 2) ? 1'($urandom_range(0, 1)) : 1'b1;
    for (int tile = 0; tile < t_tiles[idx]; tile++) begin
      got = 1'b0;
      while (!got) begin
        @(negedge clk_i);
        if (res_valid_o && res_ready_i) begin
          got = 1'b1;
          for (int w = 0; w < `XB_W; w++) begin
            exp = tmem[t_ebase[idx] + tile * `XB_W + w];
            checks++;
            assert (res_o.y[w] == exp[`XB_ACC_W-1:0]) else begin
              $display("mismatch res_o.y[%0d] tile %0d: expected %h, got %h",
                       w, tile, exp[`XB_ACC_W-1:0], res_o.y[w]);
              errors++;
            end
          end
        end
        @(posedge clk_i);
        #1;
        if (t_mode[idx] == 2) begin
          res_ready_i = 1'($urandom_range(0, 1));
        end
      end
    end
    res_ready_i = 1'b0;
  endtask

  initial begin
    int p;
    int total_beats;
    int total_tiles;
    int fails_before;
    rst_ni      = 1'b0;
    cfg_i       = '0;
    row_valid_i = 1'b0;
    row_i       = '0;
    res_ready_i = 1'b0;
    errors      = 0;
    checks      = 0;
    limit       = 0;
    beats_sent  = 0;
    limit_set   = 1'b0;
    void'($urandom(966));
    $readmemh("tests/x_stream_tests.txt", tmem);

    // Walk the records, pointers into the word array
    n_tests     = tmem[0];
    p           = 1;
    total_beats = 0;
    total_tiles = 0;
    for (int i = 0; i < n_tests; i++) begin
      t_id[i]     = tmem[p];
      t_mode[i]   = tmem[p + 1];
      t_k[i]      = tmem[p + 2];
      t_wbase[i]  = p + 3;
      t_tiles[i]  = tmem[p + 3 + `XB_KMAX];
      t_bbase[i]  = p + 4 + `XB_KMAX;
      t_ebase[i]  = t_bbase[i] + t_tiles[i] * beats_per_tile(t_k[i]);
      p           = t_ebase[i] + t_tiles[i] * `XB_W;
      total_beats += t_tiles[i] * beats_per_tile(t_k[i]);
      total_tiles += t_tiles[i];
    end
    limit     = 4 * (total_beats + total_tiles * `XB_KMAX) + 200;
    limit_set = 1'b1;

    repeat (16) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // Credits load one cycle after reset
    repeat (2) @(posedge clk_i);
    #1;
    assert (row_ready_o && !res_valid_o) else begin
      $display("row_ready_o not high or res_valid_o not low after reset");
      errors++;
    end

    for (int i = 0; i < n_tests; i++) begin
      fails_before  = errors;
      beats_sent    = 0;
      cfg_i.k_len   = 4'(t_k[i]);
      for (int k = 0; k < `XB_KMAX; k++) begin
        cfg_i.weights[k] = tmem[t_wbase[i] + k][7:0];
      end
      fork
        drive_tiles(i);
        collect_results(i);
      join
      repeat (4) @(posedge clk_i);
      #1;
      $display("test %0d mode %0d k %0d tiles %0d: %s", t_id[i], t_mode[i], t_k[i],
               t_tiles[i], (errors == fails_before) ? "ok" : "failed");
    end

    $display("tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule : x_stream_tb

// ==== tests/x_stream_tests.txt ====
// Word 0 is the test count. Per test: id mode k, weights w0..w7, tile count,
// beats row by row (element 0 in low byte), then expected y[0..3] per tile
05
01 0 8 1 2 3 4 5 6 7 8 1
01010101 01010101 02020202 02020202 03020100 07060504 00000000 00000000
24 48 a8 0
02 0 4 2 3 4 5 0 0 0 0 1
01010101 04030201 ffffffff 00000010
e 28 df2 20
03 1 4 1 1 1 1 0 0 0 0 4
01010101 02020202 03030303 04040404 05050505 06060606 07070707 08080808
09090909 0a0a0a0a 0b0b0b0b 0c0c0c0c 0d0d0d0d 0e0e0e0e 0f0f0f0f 10101010
4 8 c 10 14 18 1c 20 24 28 2c 30 34 38 3c 40
04 2 8 1 0 0 0 0 0 0 1 2
03020100 07060504 0b0a0908 0f0e0d0c 13121110 17161514 1b1a1918 1f1e1d1c
83828180 87868584 8b8a8988 8f8e8d8c 93929190 97969594 9b9a9998 9f9e9d9c
7 17 27 37 107 117 127 137
05 2 4 1 2 1 2 0 0 0 0 3
01010101 02020202 03030303 04040404 10101010 20202020 30303030 40404040
ffffffff ffffffff ffffffff ffffffff
6 c 12 18 60 c0 120 180 5fa 5fa 5fa 5fa

// ==== src.f ====
+incdir+include
logic/xbuf_pkg.sv
logic/x_row_loader.sv
logic/x_tile_buffer.sv
logic/x_dot_engine.sv
logic/x_stream_top.sv
tests/x_stream_props.sv
tests/x_stream_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= x_stream_tb
FILELIST  ?= src.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search the log for the pass message"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

$(OBJDIR)/V$(TOP): $(shell grep -v '^+' $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

test: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
